//--- list.f
wb_pkg.sv
wb_fifo.sv
write_buffer.sv
wb_regs.sv
wb_subsystem.sv
tb_wb_sva.sv
tb_wb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_wb
FILELIST ?= list.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
FAIL_MSG := Simulation failed
PASS_MSG := Simulation passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Result: FAIL"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Result: FAIL, run ended early"; exit 1; fi
	@echo "Result: PASS"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_wb.sv
`timescale 1ns/1ps
`default_nettype none

module tb_wb;

	localparam int CLK_PERIOD = 8;
	localparam int TEST_TRANS = 160;
	localparam int TIMEOUT_NS = TEST_TRANS * 16 * CLK_PERIOD + 2000;

	logic i_clock = 1'b0;
	logic i_rst_n = 1'b0;
	logic i_cpu_request = 1'b0;
	logic i_cpu_rw = 1'b0;
	logic [31:0] i_cpu_address = '0;
	logic [31:0] i_cpu_wdata = '0;
	logic o_cpu_ready;
	logic [31:0] o_cpu_rdata;
	logic o_bus_request;
	logic o_bus_rw;
	logic [31:0] o_bus_address;
	logic [31:0] o_bus_wdata;
	logic i_bus_ready = 1'b0;
	logic [31:0] i_bus_rdata = '0;
	logic i_apb_psel = 1'b0;
	logic i_apb_penable = 1'b0;
	logic i_apb_pwrite = 1'b0;
	logic [7:0] i_apb_paddr = '0;
	logic [31:0] i_apb_pwdata = '0;
	logic [31:0] o_apb_prdata;
	logic o_apb_pready;
	logic o_apb_pslverr;

	logic [31:0] mem [logic [31:0]];
	logic [31:0] ref_mem [logic [31:0]];
	logic [63:0] drain_q [$];
	logic [31:0] stim_seed = 32'hf0ce;
	logic [31:0] bus_seed = 32'hf0ce;
	logic bus_busy = 1'b0;
	logic [1:0] bus_wait = '0;
	logic pend_rw;
	logic [31:0] pend_addr;
	logic [31:0] pend_data;
	int errors = 0;
	int wr_count = 0;
	int drn_count = 0;
	int rd_count = 0;
	int test_count = 0;
	int test_passed = 0;
	int test_start_fail = 0;

	wb_subsystem uut (.*);

	always #(CLK_PERIOD / 2) i_clock = ~i_clock;

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic logic [31:0] stim_rand();
		stim_seed = lcg_step(stim_seed);
		return stim_seed;
	endfunction

	// Untouched locations read back a pattern of their own address
	function automatic logic [31:0] mem_read(input logic [31:0] addr);
		return mem.exists(addr) ? mem[addr] : (addr ^ 32'h5ac3_96e1);
	endfunction

	function automatic int failure_count();
		return errors + int'(uut.u_write_buffer.u_sva.fail_count);
	endfunction

	task automatic check_equal(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
			errors++;
		end
	endtask

	task automatic record_drain(input logic [31:0] addr, input logic [31:0] data);
		logic [63:0] exp;
		assert (drain_q.size() != 0) else begin
			$display("** Error: bus write to 0x%h with no queued write pending", addr);
			errors++;
		end
		if (drain_q.size() != 0) begin
			exp = drain_q.pop_front();
			check_equal("o_bus_address", addr, exp[63:32]);
			check_equal("o_bus_wdata", data, exp[31:0]);
		end
		mem[addr] = data;
		drn_count++;
	endtask

	// Memory slave with a random 0 to 3 cycle wait before ready
	always @(posedge i_clock) begin
		if (o_bus_request && i_bus_ready) begin
			if (o_bus_rw) begin
				record_drain(o_bus_address, o_bus_wdata);
			end
			i_bus_ready <= 1'b0;
			bus_busy = 1'b0;
		end else if (o_bus_request) begin
			if (!bus_busy) begin
				bus_seed = lcg_step(bus_seed);
				bus_wait = bus_seed[17:16];
				bus_busy = 1'b1;
			end
			if (bus_wait == 2'd0) begin
				i_bus_ready <= 1'b1;
				i_bus_rdata <= mem_read(o_bus_address);
			end else begin
				bus_wait = bus_wait - 2'd1;
			end
		end
	end

	task automatic apb_access(input logic write, input logic [7:0] addr, input logic [31:0] wdata,
			output logic [31:0] rdata, output logic err);
		@(posedge i_clock);
		i_apb_psel <= 1'b1;
		i_apb_penable <= 1'b0;
		i_apb_pwrite <= write;
		i_apb_paddr <= addr;
		i_apb_pwdata <= wdata;
		@(posedge i_clock);
		i_apb_penable <= 1'b1;
		@(negedge i_clock);
		rdata = o_apb_prdata;
		err = o_apb_pslverr;
		check_equal("o_apb_pready", 32'(o_apb_pready), 32'h1);
		@(posedge i_clock);
		i_apb_psel <= 1'b0;
		i_apb_penable <= 1'b0;
	endtask

	task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
		logic [31:0] rdata;
		logic err;
		apb_access(1'b1, addr, data, rdata, err);
		check_equal("o_apb_pslverr", 32'(err), 32'h0);
	endtask

	task automatic reg_expect(input string name, input logic [7:0] addr, input logic [31:0] exp);
		logic [31:0] rdata;
		logic err;
		apb_access(1'b0, addr, 32'h0, rdata, err);
		check_equal(name, rdata, exp);
		check_equal("o_apb_pslverr", 32'(err), 32'h0);
	endtask

	task automatic cpu_begin(input logic rw, input logic [31:0] addr, input logic [31:0] data);
		@(posedge i_clock);
		i_cpu_request <= 1'b1;
		i_cpu_rw <= rw;
		i_cpu_address <= addr;
		i_cpu_wdata <= data;
		pend_rw = rw;
		pend_addr = addr;
		pend_data = data;
	endtask

	task automatic cpu_end(output logic [31:0] rdata);
		do @(negedge i_clock); while (!o_cpu_ready);
		rdata = o_cpu_rdata;
		if (pend_rw) begin
			ref_mem[pend_addr] = pend_data;
			drain_q.push_back({pend_addr, pend_data});
			wr_count++;
		end else begin
			rd_count++;
		end
		@(posedge i_clock);
		i_cpu_request <= 1'b0;
	endtask

	task automatic cpu_write(input logic [31:0] addr, input logic [31:0] data);
		logic [31:0] unused;
		cpu_begin(1'b1, addr, data);
		cpu_end(unused);
	endtask

	task automatic cpu_read_expect(input logic [31:0] addr, input logic [31:0] exp);
		logic [31:0] rdata;
		cpu_begin(1'b0, addr, 32'h0);
		cpu_end(rdata);
		check_equal("o_cpu_rdata", rdata, exp);
	endtask

	// Poll until the queue is empty and its last bus write is done
	task automatic wait_drained();
		logic [31:0] status;
		logic err;
		status = '0;
		while (!(status[0] && drain_q.size() == 0)) begin
			apb_access(1'b0, wb_pkg::REG_STATUS, 32'h0, status, err);
		end
	endtask

	function automatic logic [31:0] rand_addr();
		logic [31:0] r;
		r = stim_rand();
		return {22'h000040, r[11:4], 2'b00};
	endfunction

	task automatic end_test(input string name);
		int now_fail;
		now_fail = failure_count();
		test_count++;
		if (now_fail == test_start_fail) begin
			test_passed++;
			$display("Test %0d %s: PASS", test_count, name);
		end else begin
			$display("Test %0d %s: FAIL with %0d errors", test_count, name,
				now_fail - test_start_fail);
		end
		test_start_fail = now_fail;
	endtask

	initial begin
		#(TIMEOUT_NS);
		$display("Watchdog expired, a handshake never completed");
		$display("Simulation failed");
		$finish;
	end

	initial begin
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] old;
		logic [31:0] rdata;
		logic err;

		repeat (16) @(posedge i_clock);
		i_rst_n <= 1'b1;

		@(negedge i_clock);
		check_equal("o_cpu_ready", 32'(o_cpu_ready), 32'h0);
		check_equal("o_bus_request", 32'(o_bus_request), 32'h0);
		reg_expect("REG_STATUS", wb_pkg::REG_STATUS, 32'h1);
		reg_expect("REG_CTRL", wb_pkg::REG_CTRL, 32'h2);
		apb_access(1'b0, 8'h20, 32'h0, rdata, err);
		check_equal("o_apb_pslverr", 32'(err), 32'h1);
		end_test("reset state");

		for (int i = 0; i < 16; i++) begin
			cpu_write(rand_addr(), stim_rand());
		end
		wait_drained();
		end_test("in-order drain");

		reg_write(wb_pkg::REG_CTRL, 32'h0);
		for (int i = 0; i < wb_pkg::WB_DEPTH; i++) begin
			cpu_write(rand_addr(), stim_rand());
		end
		cpu_begin(1'b1, rand_addr(), stim_rand());
		repeat (4) begin
			@(negedge i_clock);
			check_equal("o_cpu_ready", 32'(o_cpu_ready), 32'h0);
		end
		reg_expect("REG_STATUS", wb_pkg::REG_STATUS, 32'h42);
		reg_write(wb_pkg::REG_CTRL, 32'h2);
		cpu_end(rdata);
		wait_drained();
		reg_expect("REG_STATUS", wb_pkg::REG_STATUS, 32'h1);
		end_test("full queue back-pressure");

		reg_write(wb_pkg::REG_CTRL, 32'h3);
		for (int i = 0; i < 4; i++) begin
			addr = rand_addr();
			cpu_write(addr, stim_rand());
			cpu_read_expect(addr, ref_mem[addr]);
		end
		wait_drained();
		end_test("stalled read coherence");

		reg_write(wb_pkg::REG_CTRL, 32'h0);
		addr = 32'h0000_8000;
		old = mem_read(addr);
		data = stim_rand();
		cpu_write(addr, data);
		cpu_read_expect(addr, old);
		reg_write(wb_pkg::REG_CTRL, 32'h2);
		wait_drained();
		cpu_read_expect(addr, data);
		end_test("read bypass");

		reg_expect("REG_WCOUNT", wb_pkg::REG_WCOUNT, 32'(wr_count));
		reg_expect("REG_DCOUNT", wb_pkg::REG_DCOUNT, 32'(drn_count));
		reg_expect("REG_RCOUNT", wb_pkg::REG_RCOUNT, 32'(rd_count));
		end_test("traffic counters");

		$display("Tests: %0d run, %0d passed, %0d check errors, %0d assertion failures",
			test_count, test_passed, errors, uut.u_write_buffer.u_sva.fail_count);
		if (failure_count() == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tb_wb_sva.sv
`timescale 1ns/1ps
`default_nettype none

module tb_wb_sva (
	input logic i_clock,
	input logic i_rst_n,
	input wb_pkg::wb_state_t i_state,
	input logic i_cpu_request,
	input logic i_cpu_ready,
	input logic i_bus_request,
	input logic i_bus_rw,
	input logic [wb_pkg::WB_ADDR_W-1:0] i_bus_address,
	input logic [wb_pkg::WB_DATA_W-1:0] i_bus_wdata,
	input logic i_bus_ready,
	input logic i_stall_read,
	input logic i_fifo_empty
);

	int unsigned fail_count = 0;

	// A waiting bus request keeps every field
	bus_fields_held: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		i_bus_request && !i_bus_ready |=> i_bus_request && $stable(i_bus_rw)
			&& $stable(i_bus_address) && $stable(i_bus_wdata))
		else begin
			fail_count++;
			$error("bus fields changed while the request waited for ready");
		end

	drain_is_write: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		i_state == wb_pkg::DRAIN |-> i_bus_request && i_bus_rw)
		else begin
			fail_count++;
			$error("bus write not driven in DRAIN");
		end

	// Stall mode keeps reads off the bus until older writes are out
	no_read_past_writes: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		i_bus_request && !i_bus_rw && i_stall_read |-> i_fifo_empty)
		else begin
			fail_count++;
			$error("bus read started with writes still queued");
		end

	ready_needs_request: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		i_cpu_ready |-> i_cpu_request)
		else begin
			fail_count++;
			$error("processor ready without a request");
		end

endmodule

bind write_buffer tb_wb_sva u_sva (
	.i_clock(i_clock),
	.i_rst_n(i_rst_n),
	.i_state(state),
	.i_cpu_request(i_cpu_request),
	.i_cpu_ready(o_cpu_ready),
	.i_bus_request(o_bus_request),
	.i_bus_rw(o_bus_rw),
	.i_bus_address(o_bus_address),
	.i_bus_wdata(o_bus_wdata),
	.i_bus_ready(i_bus_ready),
	.i_stall_read(i_stall_read),
	.i_fifo_empty(fifo_empty)
);

`default_nettype wire

//--- wb_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module wb_subsystem (
	input logic i_clock,
	input logic i_rst_n,

	// Processor side
	input logic i_cpu_request,
	input logic i_cpu_rw,
	input logic [wb_pkg::WB_ADDR_W-1:0] i_cpu_address,
	input logic [wb_pkg::WB_DATA_W-1:0] i_cpu_wdata,
	output logic o_cpu_ready,
	output logic [wb_pkg::WB_DATA_W-1:0] o_cpu_rdata,

	// Memory bus
	output logic o_bus_request,
	output logic o_bus_rw,
	output logic [wb_pkg::WB_ADDR_W-1:0] o_bus_address,
	output logic [wb_pkg::WB_DATA_W-1:0] o_bus_wdata,
	input logic i_bus_ready,
	input logic [wb_pkg::WB_DATA_W-1:0] i_bus_rdata,

	// APB register access
	input logic i_apb_psel,
	input logic i_apb_penable,
	input logic i_apb_pwrite,
	input logic [wb_pkg::WB_APB_ADDR_W-1:0] i_apb_paddr,
	input logic [wb_pkg::WB_REG_W-1:0] i_apb_pwdata,
	output logic [wb_pkg::WB_REG_W-1:0] o_apb_prdata,
	output logic o_apb_pready,
	output logic o_apb_pslverr
);

	logic stall_read;
	logic drain_enable;
	logic write_accepted;
	logic drain_done;
	logic read_done;
	logic empty;
	logic full;
	logic [wb_pkg::WB_LEVEL_W-1:0] level;

	write_buffer u_write_buffer (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_cpu_request(i_cpu_request),
		.i_cpu_rw(i_cpu_rw),
		.i_cpu_address(i_cpu_address),
		.i_cpu_wdata(i_cpu_wdata),
		.o_cpu_ready(o_cpu_ready),
		.o_cpu_rdata(o_cpu_rdata),
		.o_bus_request(o_bus_request),
		.o_bus_rw(o_bus_rw),
		.o_bus_address(o_bus_address),
		.o_bus_wdata(o_bus_wdata),
		.i_bus_ready(i_bus_ready),
		.i_bus_rdata(i_bus_rdata),
		.i_stall_read(stall_read),
		.i_drain_enable(drain_enable),
		.o_write_accepted(write_accepted),
		.o_drain_done(drain_done),
		.o_read_done(read_done),
		.o_empty(empty),
		.o_full(full),
		.o_level(level)
	);

	wb_regs u_regs (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_apb_psel(i_apb_psel),
		.i_apb_penable(i_apb_penable),
		.i_apb_pwrite(i_apb_pwrite),
		.i_apb_paddr(i_apb_paddr),
		.i_apb_pwdata(i_apb_pwdata),
		.o_apb_prdata(o_apb_prdata),
		.o_apb_pready(o_apb_pready),
		.o_apb_pslverr(o_apb_pslverr),
		.i_empty(empty),
		.i_full(full),
		.i_level(level),
		.i_write_accepted(write_accepted),
		.i_drain_done(drain_done),
		.i_read_done(read_done),
		.o_stall_read(stall_read),
		.o_drain_enable(drain_enable)
	);

endmodule

`default_nettype wire

//--- wb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module wb_regs (
	input logic i_clock,
	input logic i_rst_n,

	// APB slave
	input logic i_apb_psel,
	input logic i_apb_penable,
	input logic i_apb_pwrite,
	input logic [wb_pkg::WB_APB_ADDR_W-1:0] i_apb_paddr,
	input logic [wb_pkg::WB_REG_W-1:0] i_apb_pwdata,
	output logic [wb_pkg::WB_REG_W-1:0] o_apb_prdata,
	output logic o_apb_pready,
	output logic o_apb_pslverr,

	// Buffer status and events
	input logic i_empty,
	input logic i_full,
	input logic [wb_pkg::WB_LEVEL_W-1:0] i_level,
	input logic i_write_accepted,
	input logic i_drain_done,
	input logic i_read_done,

	// Mode bits
	output logic o_stall_read,
	output logic o_drain_enable
);

	logic [wb_pkg::WB_REG_W-1:0] wcount;
	logic [wb_pkg::WB_REG_W-1:0] dcount;
	logic [wb_pkg::WB_REG_W-1:0] rcount;
	logic [wb_pkg::WB_REG_W-1:0] ctrl_word;
	logic [wb_pkg::WB_REG_W-1:0] status_word;
	logic access;
	logic mapped;

	assign access = i_apb_psel && i_apb_penable;

	assign ctrl_word = {{(wb_pkg::WB_REG_W - 2){1'b0}}, o_drain_enable, o_stall_read};

	// Bits 3:2 are reserved and read as zero
	assign status_word = {{(wb_pkg::WB_REG_W - wb_pkg::STATUS_LEVEL_LSB - wb_pkg::WB_LEVEL_W){1'b0}},
		i_level, 2'b00, i_full, i_empty};

	always_comb begin
		mapped = 1'b1;
		o_apb_prdata = '0;
		case (i_apb_paddr)
			wb_pkg::REG_CTRL: o_apb_prdata = ctrl_word;
			wb_pkg::REG_STATUS: o_apb_prdata = status_word;
			wb_pkg::REG_WCOUNT: o_apb_prdata = wcount;
			wb_pkg::REG_DCOUNT: o_apb_prdata = dcount;
			wb_pkg::REG_RCOUNT: o_apb_prdata = rcount;
			default: mapped = 1'b0;
		endcase
	end

	// No wait states
	assign o_apb_pready = 1'b1;
	assign o_apb_pslverr = access && !mapped;

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_stall_read <= 1'b0;
			o_drain_enable <= 1'b1;
		end else if (access && i_apb_pwrite && i_apb_paddr == wb_pkg::REG_CTRL) begin
			o_stall_read <= i_apb_pwdata[wb_pkg::CTRL_STALL_READ];
			o_drain_enable <= i_apb_pwdata[wb_pkg::CTRL_DRAIN_ENABLE];
		end
	end

	// Traffic counters wrap at 2**32
	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			wcount <= '0;
			dcount <= '0;
			rcount <= '0;
		end else begin
			if (i_write_accepted) begin
				wcount <= wcount + 1'b1;
			end
			if (i_drain_done) begin
				dcount <= dcount + 1'b1;
			end
			if (i_read_done) begin
				rcount <= rcount + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- write_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module write_buffer (
	input logic i_clock,
	input logic i_rst_n,

	// Processor side
	input logic i_cpu_request,
	input logic i_cpu_rw,
	input logic [wb_pkg::WB_ADDR_W-1:0] i_cpu_address,
	input logic [wb_pkg::WB_DATA_W-1:0] i_cpu_wdata,
	output logic o_cpu_ready,
	output logic [wb_pkg::WB_DATA_W-1:0] o_cpu_rdata,

	// Memory bus
	output logic o_bus_request,
	output logic o_bus_rw,
	output logic [wb_pkg::WB_ADDR_W-1:0] o_bus_address,
	output logic [wb_pkg::WB_DATA_W-1:0] o_bus_wdata,
	input logic i_bus_ready,
	input logic [wb_pkg::WB_DATA_W-1:0] i_bus_rdata,

	// Mode bits and status for the register block
	input logic i_stall_read,
	input logic i_drain_enable,
	output logic o_write_accepted,
	output logic o_drain_done,
	output logic o_read_done,
	output logic o_empty,
	output logic o_full,
	output logic [wb_pkg::WB_LEVEL_W-1:0] o_level
);

	wb_pkg::wb_state_t state;
	wb_pkg::wb_state_t next_state;

	logic fifo_push;
	logic fifo_pop;
	wb_pkg::wb_entry_t fifo_push_entry;
	wb_pkg::wb_entry_t fifo_head;
	logic fifo_empty;
	logic fifo_full;
	logic [wb_pkg::WB_LEVEL_W-1:0] fifo_level;

	// Entry being written out, captured when it leaves the queue
	wb_pkg::wb_entry_t drain_entry;
	logic read_stalled;

	wb_fifo u_fifo (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_push(fifo_push),
		.i_push_entry(fifo_push_entry),
		.i_pop(fifo_pop),
		.o_head_entry(fifo_head),
		.o_empty(fifo_empty),
		.o_full(fifo_full),
		.o_level(fifo_level)
	);

	assign fifo_push_entry.address = i_cpu_address;
	assign fifo_push_entry.data = i_cpu_wdata;

	// A read waits for older writes only in stall mode
	assign read_stalled = i_stall_read && !fifo_empty;

	assign o_cpu_rdata = i_bus_rdata;
	assign o_empty = fifo_empty;
	assign o_full = fifo_full;
	assign o_level = fifo_level;

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= wb_pkg::IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_ff @(posedge i_clock) begin
		if (fifo_pop) begin
			drain_entry <= fifo_head;
		end
	end

	always_comb begin
		next_state = state;
		fifo_push = 1'b0;
		fifo_pop = 1'b0;
		o_cpu_ready = 1'b0;
		o_bus_request = 1'b0;
		o_bus_rw = 1'b0;
		o_bus_address = '0;
		o_bus_wdata = '0;
		o_write_accepted = 1'b0;
		o_drain_done = 1'b0;
		o_read_done = 1'b0;

		case (state)
			wb_pkg::IDLE: begin
				if (i_cpu_request && i_cpu_rw && !fifo_full) begin
					// Posted write, acknowledged at once
					fifo_push = 1'b1;
					o_cpu_ready = 1'b1;
					o_write_accepted = 1'b1;
					next_state = wb_pkg::WRITE_ACK;
				end else if (i_cpu_request && !i_cpu_rw && !read_stalled) begin
					o_bus_request = 1'b1;
					o_bus_address = i_cpu_address;
					o_cpu_ready = i_bus_ready;
					if (i_bus_ready) begin
						o_read_done = 1'b1;
						next_state = wb_pkg::WRITE_ACK;
					end else begin
						next_state = wb_pkg::READ_BUS;
					end
				end else if (!fifo_empty && i_drain_enable) begin
					// Nothing accepted this cycle so the bus is free for the queue
					fifo_pop = 1'b1;
					next_state = wb_pkg::DRAIN;
				end
			end

			wb_pkg::WRITE_ACK: begin
				// Close the handshake; only a write sees ready again
				o_cpu_ready = i_cpu_request && i_cpu_rw;
				if (!i_cpu_request) begin
					next_state = wb_pkg::IDLE;
				end
			end

			wb_pkg::READ_BUS: begin
				o_bus_request = 1'b1;
				o_bus_address = i_cpu_address;
				o_cpu_ready = i_bus_ready;
				if (i_bus_ready) begin
					o_read_done = 1'b1;
					next_state = wb_pkg::WRITE_ACK;
				end
			end

			wb_pkg::DRAIN: begin
				o_bus_request = 1'b1;
				o_bus_rw = 1'b1;
				o_bus_address = drain_entry.address;
				o_bus_wdata = drain_entry.data;
				if (i_bus_ready) begin
					o_drain_done = 1'b1;
					next_state = wb_pkg::IDLE;
				end
			end

			default: begin
				next_state = wb_pkg::IDLE;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- wb_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module wb_fifo (
	input logic i_clock,
	input logic i_rst_n,
	input logic i_push,
	input wb_pkg::wb_entry_t i_push_entry,
	input logic i_pop,
	output wb_pkg::wb_entry_t o_head_entry,
	output logic o_empty,
	output logic o_full,
	output logic [wb_pkg::WB_LEVEL_W-1:0] o_level
);

	wb_pkg::wb_entry_t entries [wb_pkg::WB_DEPTH];

	logic [wb_pkg::WB_PTR_W-1:0] wr_ptr;
	logic [wb_pkg::WB_PTR_W-1:0] rd_ptr;
	logic [wb_pkg::WB_LEVEL_W-1:0] level;
	logic push_ok;
	logic pop_ok;

	// Requests that would overflow or underflow are dropped here
	assign push_ok = i_push && !o_full;
	assign pop_ok = i_pop && !o_empty;

	assign o_empty = (level == '0);
	assign o_full = (level == wb_pkg::WB_LEVEL_W'(wb_pkg::WB_DEPTH));
	assign o_level = level;
	assign o_head_entry = entries[rd_ptr];

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level <= '0;
		end else begin
			if (push_ok) begin
				if (wr_ptr == wb_pkg::WB_PTR_W'(wb_pkg::WB_DEPTH - 1)) begin
					wr_ptr <= '0;
				end else begin
					wr_ptr <= wr_ptr + 1'b1;
				end
			end
			if (pop_ok) begin
				if (rd_ptr == wb_pkg::WB_PTR_W'(wb_pkg::WB_DEPTH - 1)) begin
					rd_ptr <= '0;
				end else begin
					rd_ptr <= rd_ptr + 1'b1;
				end
			end
			// Simultaneous push and pop leaves the level unchanged
			if (push_ok && !pop_ok) begin
				level <= level + 1'b1;
			end else if (pop_ok && !push_ok) begin
				level <= level - 1'b1;
			end
		end
	end

	// Storage
	always_ff @(posedge i_clock) begin
		if (push_ok) begin
			entries[wr_ptr] <= i_push_entry;
		end
	end

endmodule

`default_nettype wire

//--- wb_pkg.sv
`default_nettype none

package wb_pkg;

	// Processor and memory bus widths
	localparam int WB_ADDR_W = 32;
	localparam int WB_DATA_W = 32;

	// Posted-write queue sizing
	localparam int WB_DEPTH = 4;
	localparam int WB_PTR_W = $clog2(WB_DEPTH);
	localparam int WB_LEVEL_W = WB_PTR_W + 1;

	// APB register block
	localparam int WB_APB_ADDR_W = 8;
	localparam int WB_REG_W = 32;

	localparam logic [WB_APB_ADDR_W-1:0] REG_CTRL = 8'h00;
	localparam logic [WB_APB_ADDR_W-1:0] REG_STATUS = 8'h04;
	localparam logic [WB_APB_ADDR_W-1:0] REG_WCOUNT = 8'h08;
	localparam logic [WB_APB_ADDR_W-1:0] REG_DCOUNT = 8'h0c;
	localparam logic [WB_APB_ADDR_W-1:0] REG_RCOUNT = 8'h10;

	// Bit positions inside REG_CTRL and REG_STATUS
	localparam int CTRL_STALL_READ = 0;
	localparam int CTRL_DRAIN_ENABLE = 1;
	localparam int STATUS_EMPTY = 0;
	localparam int STATUS_FULL = 1;
	localparam int STATUS_LEVEL_LSB = 4;

	// One queued write, address in the upper half
	typedef struct packed {
		logic [WB_ADDR_W-1:0] address;
		logic [WB_DATA_W-1:0] data;
	} wb_entry_t;

	// Controller states
	typedef enum logic [1:0] {
		IDLE = 2'd0,
		WRITE_ACK = 2'd1,
		READ_BUS = 2'd2,
		DRAIN = 2'd3
	} wb_state_t;

endpackage

`default_nettype wire
